// ==== design/fb_types_pkg.sv ====
// Scalar widths for a 16-bit RGB565 framebuffer with 32-bit memory words; pixel formats are fixed
package fb_types_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    // One RGB565 pixel
    localparam int PIXEL_BITS = 16;

    // Memory word, two pixels side by side
    localparam int WORD_BITS = 32;

    // Byte enables per memory word
    localparam int STRB_BITS = WORD_BITS / 8;

    // Linear pixel index, enough for 1M pixels
    localparam int ADDR_BITS = 20;

    // Screen coordinate, up to 2047
    localparam int XY_BITS = 11;

    ////////////////////////////////////////////////////////////
    // Scalar types
    ////////////////////////////////////////////////////////////

    // RGB565 colour, red in the top bits
    typedef logic [PIXEL_BITS-1:0] pixel_t;

    // Single x or y position
    typedef logic [XY_BITS-1:0] coord_t;

    // Pixel index, bit 0 selects the half of a word
    typedef logic [ADDR_BITS-1:0] pix_addr_t;

    // Word index is the pixel index without its low bit
    typedef logic [ADDR_BITS-2:0] word_addr_t;

    // Data bus of the memory port
    typedef logic [WORD_BITS-1:0] mem_word_t;

    // Byte enables, bit 0 for the lowest byte
    typedef logic [STRB_BITS-1:0] byte_strb_t;

endpackage

// ==== design/fb_stream_pkg.sv ====
// Stream payloads of the framebuffer write path; handshake signals travel beside them, not inside
package fb_stream_pkg;

    // Field types come from the scalar package
    import fb_types_pkg::*;

    ////////////////////////////////////////////////////////////
    // Fragment stream
    ////////////////////////////////////////////////////////////

    // One fragment as produced by the rasterizer
    typedef struct packed {
        // Colour to write
        pixel_t    color;
        // Write enable, a low strobe means the fragment is discarded
        logic      strb;
        // Linear pixel index into the framebuffer
        pix_addr_t addr;
        // Screen position, carried for downstream stages
        coord_t    xpos;
        coord_t    ypos;
        // Marks the final fragment of a batch
        logic      last;
    } frag_t;

    ////////////////////////////////////////////////////////////
    // Memory write beat
    ////////////////////////////////////////////////////////////

    // One 32-bit write towards the memory controller
    typedef struct packed {
        // Word index, pixel index divided by two
        word_addr_t addr;
        // Even pixel in the low half, odd pixel in the high half
        mem_word_t  data;
        // Byte enables, 4'b0011 low pixel, 4'b1100 high pixel
        byte_strb_t strb;
        // Beat that carries the end of a batch
        logic       last;
    } mem_wr_t;

endpackage

// ==== design/fb_frag_fifo.sv ====
// Fragment queue of DEPTH entries plus one output register; DEPTH must be at least 2
module fb_frag_fifo
    import fb_stream_pkg::*;
#(
    parameter int DEPTH = 4
)
(
    input  logic  aclk,
    input  logic  resetn,

    // Fragments from the rasterizer
    input  frag_t s_frag,
    input  logic  s_frag_valid,
    output logic  s_frag_ready,

    // Fragments towards the clear stage
    output frag_t m_frag,
    output logic  m_frag_valid,
    input  logic  m_frag_ready
);

    localparam int PTR_BITS = $clog2(DEPTH);
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    // Storage, no reset needed
    frag_t mem [DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    logic in_fire;
    logic out_load;
    logic pop;
    logic bypass;
    logic push;

    // Pointer advance with wrap at DEPTH, works for any depth
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(DEPTH - 1))
            return '0;
        return ptr + PTR_BITS'(1);
    endfunction

    // Full only when every storage slot is taken
    assign s_frag_ready = (count != CNT_BITS'(DEPTH));
    assign in_fire      = s_frag_valid && s_frag_ready;

    // Output register empty or being drained this cycle
    assign out_load = !m_frag_valid || m_frag_ready;

    // Oldest stored entry goes first
    assign pop    = out_load && (count != '0);
    // Empty queue, so the new fragment skips the storage
    assign bypass = out_load && (count == '0) && in_fire;
    assign push   = in_fire && !bypass;

    ////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            m_frag_valid <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);

            // Occupancy follows push and pop
            case ({push, pop})
                2'b10:   count <= count + CNT_BITS'(1);
                2'b01:   count <= count - CNT_BITS'(1);
                default: count <= count;
            endcase

            if (out_load)
                m_frag_valid <= pop || bypass;
        end
    end

    // Payload path
    always_ff @(posedge aclk)
    begin
        if (push)
            mem[wr_ptr] <= s_frag;
        if (pop)
            m_frag <= mem[rd_ptr];
        else if (bypass)
            m_frag <= s_frag;
    end

endmodule

// ==== design/fb_clear.sv ====
// Screen clear stage; x_res and y_res must be nonzero and stay stable while a sweep is running
module fb_clear
    import fb_types_pkg::*;
    import fb_stream_pkg::*;
(
    input  logic   aclk,
    input  logic   resetn,

    // Clear configuration
    input  pixel_t clear_color,
    input  coord_t x_res,
    input  coord_t y_res,

    // Fragments from the queue
    input  frag_t  s_frag,
    input  logic   s_frag_valid,
    output logic   s_frag_ready,

    // Fragments towards the packer
    output frag_t  m_frag,
    output logic   m_frag_valid,
    input  logic   m_frag_ready,

    // Start pulse and done level
    input  logic   apply,
    output logic   applied
);

    typedef enum logic [0:0] {
        ST_IDLE,
        ST_CLEAR
    } state_t;

    state_t state;

    // Sweep position
    pix_addr_t clr_addr;
    coord_t    clr_x;
    coord_t    clr_y;

    // Last column and last row of the configured screen
    coord_t x_max;
    coord_t y_max;
    logic   x_end;

    // Generated clear fragment
    frag_t  clr_frag;

    assign x_max = x_res - coord_t'(1);
    assign y_max = y_res - coord_t'(1);
    assign x_end = (clr_x == x_max);

    always_comb
    begin
        clr_frag       = '0;
        clr_frag.color = clear_color;
        clr_frag.strb  = 1'b1;
        clr_frag.addr  = clr_addr;
        clr_frag.xpos  = clr_x;
        clr_frag.ypos  = clr_y;
        // Only the bottom right pixel closes the sweep
        clr_frag.last  = x_end && (clr_y == y_max);
    end

    ////////////////////////////////////////////////////////////
    // Output select
    ////////////////////////////////////////////////////////////

    assign applied = (state == ST_IDLE);

    // Idle is a plain wire path, clearing blocks the queue
    assign m_frag       = applied ? s_frag : clr_frag;
    assign m_frag_valid = applied ? s_frag_valid : 1'b1;
    assign s_frag_ready = applied ? m_frag_ready : 1'b0;

    ////////////////////////////////////////////////////////////
    // Sweep FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state    <= ST_IDLE;
            clr_addr <= '0;
            clr_x    <= '0;
            clr_y    <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    // Restart from the top left corner
                    if (apply)
                    begin
                        state    <= ST_CLEAR;
                        clr_addr <= '0;
                        clr_x    <= '0;
                        clr_y    <= '0;
                    end
                end
                ST_CLEAR:
                begin
                    // Advance only on an accepted pixel
                    if (m_frag_ready)
                    begin
                        if (clr_frag.last)
                            state <= ST_IDLE;
                        else if (x_end)
                        begin
                            clr_x <= '0;
                            clr_y <= clr_y + coord_t'(1);
                        end
                        else
                            clr_x <= clr_x + coord_t'(1);
                        clr_addr <= clr_addr + pix_addr_t'(1);
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== design/fb_write_packer.sv ====
// Pixel pair packer; a trailing even pixel without last waits until a partner or a last arrives
module fb_write_packer
    import fb_types_pkg::*;
    import fb_stream_pkg::*;
(
    input  logic    aclk,
    input  logic    resetn,

    // Fragments from the clear stage
    input  frag_t   s_frag,
    input  logic    s_frag_valid,
    output logic    s_frag_ready,

    // Memory write beats
    output mem_wr_t m_wr,
    output logic    m_wr_valid,
    input  logic    m_wr_ready
);

    // Pending pixel waiting for its odd neighbour
    frag_t   pend_frag;
    logic    pend_valid;
    logic    pend_flush;

    logic    out_free;
    logic    in_fire;
    logic    in_keep;
    logic    in_flush;
    logic    drop_last;
    logic    pair_ok;

    // Next beat and pending updates
    logic    emit;
    mem_wr_t beat;
    logic    pend_load;
    logic    pend_clear;

    // Single pixel placed in its half of the word
    function automatic mem_wr_t single_beat(input frag_t f);
        mem_wr_t b;
        b.addr = f.addr[ADDR_BITS-1:1];
        b.data = f.addr[0] ? {f.color, pixel_t'(0)} : {pixel_t'(0), f.color};
        b.strb = f.addr[0] ? 4'b1100 : 4'b0011;
        b.last = f.last;
        return b;
    endfunction

    // Even and odd pixel of one word in a full beat
    function automatic mem_wr_t pair_beat(input frag_t lo, input frag_t hi);
        mem_wr_t b;
        b.addr = lo.addr[ADDR_BITS-1:1];
        b.data = {hi.color, lo.color};
        b.strb = '1;
        b.last = hi.last;
        return b;
    endfunction

    // Output register empty or draining
    assign out_free     = !m_wr_valid || m_wr_ready;
    assign s_frag_ready = out_free;
    assign in_fire      = s_frag_valid && s_frag_ready;
    assign in_keep      = in_fire && s_frag.strb;
    // Dropped fragment still closing a batch
    assign drop_last    = in_fire && !s_frag.strb && s_frag.last;

    // Odd or last pixels never wait for a partner
    assign in_flush   = s_frag.addr[0] || s_frag.last;
    assign pend_flush = pend_frag.addr[0] || pend_frag.last;

    // Incoming odd pixel completes the pending even one
    assign pair_ok = pend_valid && !pend_flush && s_frag.addr[0]
        && (s_frag.addr[ADDR_BITS-1:1] == pend_frag.addr[ADDR_BITS-1:1]);

    ////////////////////////////////////////////////////////////
    // Pairing rules
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        emit       = 1'b0;
        beat       = single_beat(pend_frag);
        pend_load  = 1'b0;
        pend_clear = 1'b0;
        if (in_keep)
        begin
            if (pair_ok)
            begin
                emit       = 1'b1;
                beat       = pair_beat(pend_frag, s_frag);
                pend_clear = 1'b1;
            end
            else if (pend_valid)
            begin
                // Unmatched pending pixel leaves alone, the new one takes its place
                emit      = 1'b1;
                pend_load = 1'b1;
            end
            else if (in_flush)
            begin
                emit = 1'b1;
                beat = single_beat(s_frag);
            end
            else
                pend_load = 1'b1;
        end
        else if (out_free && pend_valid && (pend_flush || drop_last))
        begin
            // Pending pixel that cannot pair, or a batch end arrived on a dropped fragment
            emit       = 1'b1;
            beat.last  = pend_frag.last || drop_last;
            pend_clear = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            pend_valid <= 1'b0;
            m_wr_valid <= 1'b0;
        end
        else
        begin
            if (pend_load)
                pend_valid <= 1'b1;
            else if (pend_clear)
                pend_valid <= 1'b0;
            if (out_free)
                m_wr_valid <= emit;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (pend_load)
            pend_frag <= s_frag;
        // Payload only changes when the register may be reloaded
        if (out_free && emit)
            m_wr <= beat;
    end

endmodule

// ==== design/fb_write_unit.sv ====
// Framebuffer write path top; apply is a single-cycle pulse taken only while applied is high
module fb_write_unit
    import fb_types_pkg::*;
    import fb_stream_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  logic    aclk,
    input  logic    resetn,

    // Clear configuration
    input  pixel_t  clear_color,
    input  coord_t  x_res,
    input  coord_t  y_res,

    // Clear control
    input  logic    apply,
    output logic    applied,

    // Fragment input
    input  frag_t   s_frag,
    input  logic    s_frag_valid,
    output logic    s_frag_ready,

    // Memory write port
    output mem_wr_t m_wr,
    output logic    m_wr_valid,
    input  logic    m_wr_ready
);

    // Queue to clear stage
    frag_t q_frag;
    logic  q_frag_valid;
    logic  q_frag_ready;

    // Clear stage to packer
    frag_t c_frag;
    logic  c_frag_valid;
    logic  c_frag_ready;

    ////////////////////////////////////////////////////////////
    // Pipeline
    ////////////////////////////////////////////////////////////

    // Decouples the rasterizer from the clear stage
    fb_frag_fifo #(
        .DEPTH        (FIFO_DEPTH)
    ) u_fb_frag_fifo (
        .aclk         (aclk),
        .resetn       (resetn),
        .s_frag       (s_frag),
        .s_frag_valid (s_frag_valid),
        .s_frag_ready (s_frag_ready),
        .m_frag       (q_frag),
        .m_frag_valid (q_frag_valid),
        .m_frag_ready (q_frag_ready)
    );

    fb_clear u_fb_clear (
        .aclk         (aclk),
        .resetn       (resetn),
        .clear_color  (clear_color),
        .x_res        (x_res),
        .y_res        (y_res),
        .s_frag       (q_frag),
        .s_frag_valid (q_frag_valid),
        .s_frag_ready (q_frag_ready),
        .m_frag       (c_frag),
        .m_frag_valid (c_frag_valid),
        .m_frag_ready (c_frag_ready),
        .apply        (apply),
        .applied      (applied)
    );

    // Word packing towards memory
    fb_write_packer u_fb_write_packer (
        .aclk         (aclk),
        .resetn       (resetn),
        .s_frag       (c_frag),
        .s_frag_valid (c_frag_valid),
        .s_frag_ready (c_frag_ready),
        .m_wr         (m_wr),
        .m_wr_valid   (m_wr_valid),
        .m_wr_ready   (m_wr_ready)
    );

endmodule

// ==== bench/fb_write_unit_properties.sv ====
// Handshake checks bound into fb_write_unit; the input stream hold check also covers the driver
module fb_write_unit_properties
    import fb_stream_pkg::*;
(
    input logic    aclk,
    input logic    resetn,
    input frag_t   s_frag,
    input logic    s_frag_valid,
    input logic    s_frag_ready,
    input mem_wr_t m_wr,
    input logic    m_wr_valid,
    input logic    m_wr_ready,
    input logic    applied,
    input frag_t   q_frag,
    input logic    q_frag_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // Fragment input holds while stalled
    assert property (@(posedge aclk) disable iff (!resetn)
        s_frag_valid && !s_frag_ready |=> s_frag_valid && $stable(s_frag))
        else $error("s_frag dropped or changed under stall");

    // Write beat holds while stalled
    assert property (@(posedge aclk) disable iff (!resetn)
        m_wr_valid && !m_wr_ready |=> m_wr_valid && $stable(m_wr))
        else $error("m_wr dropped or changed under stall");

    // Fragment waiting at the queue output stays put during a sweep
    assert property (@(posedge aclk) disable iff (!resetn)
        !applied && q_frag_valid |=> q_frag_valid && $stable(q_frag))
        else $error("queue output consumed or changed while clearing");

    // No beat straight out of reset
    assert property (@(posedge aclk) !resetn |=> !m_wr_valid)
        else $error("m_wr_valid high after reset");

endmodule

// ==== bench/fb_write_unit_tb.sv ====
// Testbench for fb_write_unit; screen 8 x 4, memory model covers pixel addresses 0 to 63 only
module fb_write_unit_tb
    import fb_types_pkg::*;
    import fb_stream_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NPIX = 64;
    localparam int NWORDS = NPIX / 2;
    // Pixels over all tests, with headroom for stalls
    localparam int TOTAL_PIX = 32 + 40 + 24 + 9 + 24;
    localparam int LIMIT_CYCLES = TOTAL_PIX * 4 + 400;

    logic aclk = 1'b0;
    logic resetn = 1'b0;
    pixel_t clear_color = '0;
    coord_t x_res = coord_t'(8);
    coord_t y_res = coord_t'(4);
    logic apply = 1'b0;
    logic applied;
    frag_t s_frag = '0;
    logic s_frag_valid = 1'b0;
    logic s_frag_ready;
    mem_wr_t m_wr;
    logic m_wr_valid;
    logic m_wr_ready = 1'b1;
    logic stall_en = 1'b0;

    // Memory model and snapshots
    mem_word_t mem_model [NWORDS];
    mem_word_t snap_before [NWORDS];
    // Expected pixel image and pairing state of the reference
    pixel_t ref_pix [NPIX];
    pixel_t ref_before [NPIX];
    int ref_pend;
    int ref_beats;

    // Beat statistics, monotonic
    int beat_cnt = 0;
    int full_cnt = 0;
    int last_cnt = 0;
    logic final_last = 1'b0;
    int check_cnt = 0;
    int err_cnt = 0;
    int unsigned lcg_state = 32'd12091;

    frag_t t2_list [$];
    frag_t t3_list [$];
    frag_t t4_list [$];

    fb_write_unit #(
        .FIFO_DEPTH   (4)
    ) u_fb_write_unit (
        .aclk         (aclk),
        .resetn       (resetn),
        .clear_color  (clear_color),
        .x_res        (x_res),
        .y_res        (y_res),
        .apply        (apply),
        .applied      (applied),
        .s_frag       (s_frag),
        .s_frag_valid (s_frag_valid),
        .s_frag_ready (s_frag_ready),
        .m_wr         (m_wr),
        .m_wr_valid   (m_wr_valid),
        .m_wr_ready   (m_wr_ready)
    );

    bind fb_write_unit fb_write_unit_properties u_fb_write_unit_properties (
        .aclk         (aclk),
        .resetn       (resetn),
        .s_frag       (s_frag),
        .s_frag_valid (s_frag_valid),
        .s_frag_ready (s_frag_ready),
        .m_wr         (m_wr),
        .m_wr_valid   (m_wr_valid),
        .m_wr_ready   (m_wr_ready),
        .applied      (applied),
        .q_frag       (q_frag),
        .q_frag_valid (q_frag_valid)
    );

    always #20 aclk = ~aclk;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;
    endfunction

    // Initial memory contents, every address distinct
    function automatic pixel_t fill_pixel(input int a);
        return pixel_t'(a * 16'd937 + 16'h5a5a);
    endfunction

    function automatic frag_t make_frag(input int a, input pixel_t c, input logic s,
                                        input logic l);
        frag_t f;
        f.color = c;
        f.strb  = s;
        f.addr  = pix_addr_t'(a);
        f.xpos  = coord_t'(a % 8);
        f.ypos  = coord_t'(a / 8);
        f.last  = l;
        return f;
    endfunction

    // Reference step for one written pixel, following the pairing rules
    function automatic void ref_pixel(input int a, input pixel_t c, input logic l);
        ref_pix[a] = c;
        if (ref_pend >= 0)
        begin
            ref_beats++;
            if (a == ref_pend + 1)
            begin
                ref_pend = -1;
                return;
            end
            ref_pend = -1;
        end
        if ((a % 2) == 1 || l)
            ref_beats++;
        else
            ref_pend = a;
    endfunction

    // Expected image and beat count for a clear followed by a fragment list
    function automatic int ref_expect(input logic do_clear, input pixel_t c,
                                      input int xr, input int yr, input frag_t fl [$]);
        ref_beats = 0;
        ref_pend  = -1;
        if (do_clear)
            for (int i = 0; i < xr * yr; i++)
                ref_pixel(i, c, i == xr * yr - 1);
        foreach (fl[i])
            if (fl[i].strb)
                ref_pixel(int'(fl[i].addr), fl[i].color, fl[i].last);
        return ref_beats;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        err_cnt++;
        $display("** Error at %0t: %s expected %h got %h", $time, name, exp, got);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        check_cnt++;
        if (exp !== got)
            report_mismatch(name, exp, got);
    endtask

    // Memory model against the reference image
    task automatic check_image(input string tag);
        for (int w = 0; w < NWORDS; w++)
            check_value($sformatf("%s mem_model[%0d]", tag, w),
                        {ref_pix[2*w+1], ref_pix[2*w]}, mem_model[w]);
    endtask

    task automatic send_list(input frag_t fl [$]);
        foreach (fl[i])
        begin
            s_frag       <= fl[i];
            s_frag_valid <= 1'b1;
            do
                @(posedge aclk);
            while (!s_frag_ready);
        end
        s_frag_valid <= 1'b0;
    endtask

    task automatic pulse_apply(input pixel_t c);
        clear_color <= c;
        apply       <= 1'b1;
        @(posedge aclk);
        apply       <= 1'b0;
    endtask

    task automatic wait_beats(input int base, input int n);
        while (beat_cnt - base < n)
            @(posedge aclk);
        repeat (2) @(posedge aclk);
    endtask

    ////////////////////////////////////////////////////////////
    // Memory model and stall driver
    ////////////////////////////////////////////////////////////

    always @(posedge aclk)
    begin
        if (resetn && m_wr_valid && m_wr_ready)
        begin
            if (int'(m_wr.addr) < NWORDS)
                for (int b = 0; b < 4; b++)
                    if (m_wr.strb[b])
                        mem_model[m_wr.addr][8*b +: 8] = m_wr.data[8*b +: 8];
            beat_cnt++;
            if (m_wr.strb == 4'hf)
                full_cnt++;
            if (m_wr.last)
                last_cnt++;
            final_last = m_wr.last;
        end
    end

    // Roughly one stalled cycle in four
    always @(posedge aclk)
    begin
        if (stall_en)
            m_wr_ready <= (lcg_next() % 4) != 0;
        else
            m_wr_ready <= 1'b1;
    end

    // Run limit derived from the pixel totals
    initial
    begin
        #(LIMIT_CYCLES * 40);
        $display("Watchdog expired, the DUT stopped producing write beats");
        $display("tests failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        int exp_n;
        int base;
        int base_full;
        int base_last;
        int sweep_cycles;
        frag_t none [$];

        for (int i = 0; i < NPIX; i++)
            ref_pix[i] = fill_pixel(i);
        for (int w = 0; w < NWORDS; w++)
            mem_model[w] = {fill_pixel(2*w+1), fill_pixel(2*w)};
        repeat (10) @(posedge aclk);
        resetn <= 1'b1;
        repeat (2) @(posedge aclk);

        // Test 1, plain clear sweep
        base      = beat_cnt;
        base_full = full_cnt;
        base_last = last_cnt;
        exp_n = ref_expect(1'b1, 16'hf81f, 8, 4, none);
        pulse_apply(16'hf81f);
        wait_beats(base, exp_n);
        check_value("sweep beat count", exp_n, beat_cnt - base);
        check_value("sweep full beats", exp_n, full_cnt - base_full);
        check_value("sweep last count", 1, last_cnt - base_last);
        check_value("sweep final last", 1, final_last);
        check_image("t1");

        // Test 2, fragments queued behind a sweep
        t2_list = {make_frag(3, 16'h1111, 1, 0), make_frag(4, 16'h2222, 1, 0),
                   make_frag(5, 16'h3333, 1, 0), make_frag(9, 16'h4444, 1, 0),
                   make_frag(10, 16'h5555, 1, 0), make_frag(11, 16'h6666, 1, 0),
                   make_frag(30, 16'h7777, 1, 0), make_frag(31, 16'h8888, 1, 1)};
        base  = beat_cnt;
        exp_n = ref_expect(1'b1, 16'h07e0, 8, 4, t2_list);
        pulse_apply(16'h07e0);
        @(posedge aclk);
        check_value("applied after apply", 0, applied);
        sweep_cycles = 0;
        fork
            send_list(t2_list);
            while (!applied)
            begin
                @(posedge aclk);
                sweep_cycles++;
            end
        join
        // Without back-pressure the sweep takes one cycle per screen pixel
        check_value("applied low cycles", 8 * 4, sweep_cycles);
        wait_beats(base, exp_n);
        check_value("t2 beat count", exp_n, beat_cnt - base);
        check_image("t2");

        // Test 3, random strobes and colours, last pixel always written
        for (int a = 16; a < 40; a++)
            t3_list.push_back(make_frag(a, pixel_t'(lcg_next()),
                                        (a == 39) || ((lcg_next() % 3) != 0), a == 39));
        snap_before = mem_model;
        ref_before  = ref_pix;
        base  = beat_cnt;
        exp_n = ref_expect(1'b0, '0, 0, 0, t3_list);
        send_list(t3_list);
        wait_beats(base, exp_n);
        check_value("t3 beat count", exp_n, beat_cnt - base);
        check_image("t3");

        // Test 4, pairs mixed with isolated pixels
        t4_list = {make_frag(0, 16'ha001, 1, 0), make_frag(1, 16'ha002, 1, 0),
                   make_frag(4, 16'ha003, 1, 0), make_frag(7, 16'ha004, 1, 0),
                   make_frag(10, 16'ha005, 1, 0), make_frag(11, 16'ha006, 1, 0),
                   make_frag(13, 16'ha007, 1, 0), make_frag(20, 16'ha008, 1, 0),
                   make_frag(21, 16'ha009, 1, 1)};
        base      = beat_cnt;
        base_full = full_cnt;
        exp_n = ref_expect(1'b0, '0, 0, 0, t4_list);
        send_list(t4_list);
        wait_beats(base, exp_n);
        check_value("t4 beat count", exp_n, beat_cnt - base);
        check_value("t4 full beats", 3, full_cnt - base_full);
        check_image("t4");

        // Test 5, test 3 replayed under write stalls
        mem_model = snap_before;
        ref_pix   = ref_before;
        base  = beat_cnt;
        exp_n = ref_expect(1'b0, '0, 0, 0, t3_list);
        stall_en <= 1'b1;
        send_list(t3_list);
        wait_beats(base, exp_n);
        stall_en <= 1'b0;
        check_value("t5 beat count", exp_n, beat_cnt - base);
        check_image("t5");

        $display("Checks run %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== fb_write_unit.f ====
design/fb_types_pkg.sv
design/fb_stream_pkg.sv
design/fb_frag_fifo.sv
design/fb_clear.sv
design/fb_write_packer.sv
design/fb_write_unit.sv
bench/fb_write_unit_properties.sv
bench/fb_write_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds with Verilator and runs the fb_write_unit testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module fb_write_unit_tb \
    -f fb_write_unit.f \
    -o fb_write_unit_sim \
    && ./obj_dir/fb_write_unit_sim | grep "all tests passed" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
